// File: hdl/rom_params.svh
`ifndef ROM_PARAMS_SVH
`define ROM_PARAMS_SVH

// Byte offsets of the ROM regions in SDRAM, main ROM sits at 0
`define SND_START   22'h01_0000
`define SCR_START   22'h01_2000
`define OBJ_START   22'h02_2000
`define PROM_START  25'h04_2000  // PROMs go to BRAM, not SDRAM

// Slot address widths
`define SCR_AW      14  // 32-bit words
`define OBJ_AW      15  // 32-bit words
`define SND_AW      13
`define MAIN_AW     16

// Pixel clock enable ratios
`define CEN_N60     10'd1   // 12 MHz from 48 MHz
`define CEN_M60     10'd4
`define CEN_N       10'd32  // ~12.288 MHz
`define CEN_M       10'd125

`endif

// File: hdl/rom_map_pkg.sv
package rom_map_pkg;

// Region a loader byte falls into
typedef enum logic [2:0] {
    REG_MAIN,
    REG_SND,
    REG_SCR,
    REG_OBJ,
    REG_PROM
} region_t;

// SDRAM word address used while programming
typedef logic [21:0] prog_addr_t;

// Byte enables, active low, bit 0 is the low byte
typedef logic [1:0]  prog_mask_t;

localparam prog_mask_t MASK_EVEN = 2'b10;   // low byte written
localparam prog_mask_t MASK_ODD  = 2'b01;   // high byte written

endpackage

// File: hdl/sdram_pkg.sv
package sdram_pkg;

typedef logic [21:0] sdram_addr_t;  // 16-bit word address
typedef logic [15:0] sdram_word_t;
typedef logic [ 1:0] slot_idx_t;

// Slot numbering, also the bit position in req/gnt/dst/rdy
localparam slot_idx_t SLOT_SCR  = 2'd0;
localparam slot_idx_t SLOT_OBJ  = 2'd1;
localparam slot_idx_t SLOT_SND  = 2'd2;
localparam slot_idx_t SLOT_MAIN = 2'd3;

localparam int SLOT_N = 4;

endpackage

// File: hdl/frac_cen.sv
`timescale 1ns/1ps

// Clock enable at n/m of the clock rate, plus a half-rate enable
module frac_cen #(
    parameter int W = 10
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic [W-1:0] n,
    input  logic [W-1:0] m,
    output logic         cen2,
    output logic         cen
);

logic [W:0] acc;
logic [W:0] sum;
logic       over;
logic       phase;

assign sum  = acc + {1'b0, n};
assign over = sum >= {1'b0, m};

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        acc   <= '0;
        cen2  <= 1'b0;
        cen   <= 1'b0;
        phase <= 1'b0;
    end else begin
        cen2 <= over;
        cen  <= over & phase;   // every second cen2
        if (over) begin
            acc   <= sum - {1'b0, m};
            phase <= ~phase;
        end else begin
            acc <= sum;
        end
    end
end

endmodule

// File: hdl/rom_dwnld.sv
`timescale 1ns/1ps
`include "rom_params.svh"

module rom_dwnld import rom_map_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [ 7:0] ioctl_dout,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    output prog_addr_t  prog_addr,
    output logic [15:0] prog_data,
    output prog_mask_t  prog_mask,
    output logic        prog_we,
    output logic        prom_we
);

localparam logic [24:0] SND_START  = 25'(`SND_START);
localparam logic [24:0] SCR_START  = 25'(`SCR_START);
localparam logic [24:0] OBJ_START  = 25'(`OBJ_START);
localparam logic [24:0] PROM_START = `PROM_START;

region_t    region;
prog_addr_t plain_addr;
prog_addr_t swz_addr;
logic       wr_en;

assign wr_en      = downloading & ioctl_wr;
assign plain_addr = ioctl_addr[22:1];

always_comb begin
    if (ioctl_addr >= PROM_START) begin
        region = REG_PROM;
    end else if (ioctl_addr >= OBJ_START) begin
        region = REG_OBJ;
    end else if (ioctl_addr >= SCR_START) begin
        region = REG_SCR;
    end else if (ioctl_addr >= SND_START) begin
        region = REG_SND;
    end else begin
        region = REG_MAIN;
    end
end

// Graphics words reordered so a fetch pair gives whole pixel words
always_comb begin
    swz_addr = plain_addr;
    case (region)
        REG_SCR: begin
            swz_addr[0]   = ~plain_addr[3];
            swz_addr[3:1] =  plain_addr[2:0];
        end
        REG_OBJ: begin
            swz_addr[0]   = ~plain_addr[3];
            swz_addr[1]   = ~plain_addr[4];
            swz_addr[5:2] = {plain_addr[5], plain_addr[2:0]};
        end
        default: ;
    endcase
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        prog_we <= 1'b0;
        prom_we <= 1'b0;
    end else begin
        prom_we <= wr_en && region == REG_PROM;
        if (sdram_ack) prog_we <= 1'b0;
        if (wr_en && region != REG_PROM) prog_we <= 1'b1;   // new byte wins over ack
    end
end

always_ff @(posedge clk) begin
    if (wr_en) begin
        // PROM bytes carry their offset inside the PROM area
        prog_addr <= region == REG_PROM ? prog_addr_t'(ioctl_addr - PROM_START) : swz_addr;
        prog_data <= {2{ioctl_dout}};
        prog_mask <= ioctl_addr[0] ? MASK_ODD : MASK_EVEN;
    end
end

// Loader must wait for the previous SDRAM write
a_no_overrun: assert property (@(posedge clk) disable iff (!arst_n)
    ioctl_wr |-> !prog_we || sdram_ack);

endmodule

// File: hdl/rom_slot.sv
`timescale 1ns/1ps

// ROM slot with a one-entry cache
module rom_slot import sdram_pkg::*; #(
    parameter type data_t = logic [31:0],
    parameter int  AW     = 14
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    input  sdram_addr_t   offset,
    output data_t         dout,
    output logic          ok,
    output logic          req,
    output sdram_addr_t   req_addr,
    input  logic          gnt,
    input  logic          dst,
    input  logic          rdy,
    input  sdram_word_t   word
);

localparam int WORDS = ($bits(data_t) > 16) ? 2 : 1;
localparam int BW    = 16 * WORDS;

sdram_addr_t     word_addr;
sdram_addr_t     tag;
logic            valid;
logic            busy;      // request in flight
logic            hit;
logic [BW-1:0]   fill_q;

always_comb begin
    if (WORDS == 2) begin
        word_addr = sdram_addr_t'({addr, 1'b0});
    end else begin
        word_addr = sdram_addr_t'(addr >> 1);
    end
end

assign hit = valid && word_addr == tag;
assign ok  = cs && hit;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        valid <= 1'b0;
        busy  <= 1'b0;
        req   <= 1'b0;
    end else begin
        if (gnt) req <= 1'b0;
        if (busy && rdy) begin
            busy  <= 1'b0;
            valid <= 1'b1;
        end else if (!busy && cs && !hit) begin
            busy  <= 1'b1;
            req   <= 1'b1;
            valid <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (!busy && cs && !hit) begin
        tag      <= word_addr;
        req_addr <= offset + word_addr;
    end
end

generate
    if (WORDS == 2) begin : g_wide
        // Low word arrives first
        always_ff @(posedge clk) begin
            if (busy && dst) fill_q <= {word, fill_q[BW-1 -: 16]};
        end
        assign dout = data_t'(fill_q);
    end else begin : g_byte
        always_ff @(posedge clk) begin
            if (busy && dst) fill_q <= word;
        end
        assign dout = data_t'(addr[0] ? fill_q[15:8] : fill_q[7:0]);  // odd byte high
    end
endgenerate

// Grant only comes to a pending request
a_gnt_req: assert property (@(posedge clk) disable iff (!arst_n)
    gnt |-> req);

endmodule

// File: hdl/rom_arbiter.sv
`timescale 1ns/1ps

module rom_arbiter import rom_map_pkg::*, sdram_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                downloading,
    input  logic                prog_we,
    input  prog_addr_t          prog_addr,
    input  logic [SLOT_N-1:0]   req,
    input  sdram_addr_t         req_addr [SLOT_N],
    output logic [SLOT_N-1:0]   gnt,
    output logic [SLOT_N-1:0]   dst,
    output logic [SLOT_N-1:0]   rdy,
    output logic                sdram_req,
    output sdram_addr_t         sdram_addr,
    input  logic                sdram_ack,
    input  logic                data_dst,
    input  logic                data_rdy
);

slot_idx_t   pick;
slot_idx_t   owner;
logic        start;
logic        busy;
logic        req_q;
sdram_addr_t addr_q;

// Fixed priority, main CPU ahead of sound
always_comb begin
    if (req[SLOT_SCR]) begin
        pick = SLOT_SCR;
    end else if (req[SLOT_OBJ]) begin
        pick = SLOT_OBJ;
    end else if (req[SLOT_MAIN]) begin
        pick = SLOT_MAIN;
    end else begin
        pick = SLOT_SND;
    end
end

assign start = |req && !busy && !downloading;

always_comb begin
    gnt = '0;
    dst = '0;
    rdy = '0;
    if (start) gnt[pick] = 1'b1;
    if (busy) begin
        dst[owner] = data_dst;
        rdy[owner] = data_rdy;
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        busy  <= 1'b0;
        req_q <= 1'b0;
        owner <= SLOT_SCR;
    end else if (start) begin
        busy  <= 1'b1;
        req_q <= 1'b1;
        owner <= pick;
    end else begin
        if (sdram_ack) req_q <= 1'b0;
        if (data_rdy)  busy  <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (start) addr_q <= req_addr[pick];
end

// Loader owns the port during download
assign sdram_req  = downloading ? prog_we : req_q;
assign sdram_addr = downloading ? sdram_addr_t'(prog_addr) : addr_q;

a_rdy_owned: assert property (@(posedge clk) disable iff (!arst_n || downloading)
    data_rdy |-> busy);

endmodule

// File: hdl/rom_sys_top.sv
`timescale 1ns/1ps
`include "rom_params.svh"

module rom_sys_top import rom_map_pkg::*, sdram_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 sel60,      // 12 MHz pixel clock instead of 12.288
    output logic                 pxl2_cen,
    output logic                 pxl_cen,
    // ROM download
    input  logic                 downloading,
    input  logic [24:0]          ioctl_addr,
    input  logic [ 7:0]          ioctl_dout,
    input  logic                 ioctl_wr,
    output prog_addr_t           prog_addr,
    output logic [15:0]          prog_data,
    output prog_mask_t           prog_mask,
    output logic                 prog_we,
    output logic                 prom_we,
    // ROM slots
    input  logic                 scr_cs,
    input  logic [`SCR_AW-1:0]   scr_addr,
    output logic [31:0]          scr_data,
    output logic                 scr_ok,
    input  logic                 obj_cs,
    input  logic [`OBJ_AW-1:0]   obj_addr,
    output logic [31:0]          obj_data,
    output logic                 obj_ok,
    input  logic                 snd_cs,
    input  logic [`SND_AW-1:0]   snd_addr,
    output logic [ 7:0]          snd_data,
    output logic                 snd_ok,
    input  logic                 main_cs,
    input  logic [`MAIN_AW-1:0]  main_addr,
    output logic [ 7:0]          main_data,
    output logic                 main_ok,
    // SDRAM
    output logic                 sdram_req,
    output sdram_addr_t          sdram_addr,
    input  logic                 sdram_ack,
    input  sdram_word_t          data_read,
    input  logic                 data_dst,
    input  logic                 data_rdy
);

localparam sdram_addr_t SCR_OFFSET  = sdram_addr_t'(`SCR_START >> 1);
localparam sdram_addr_t OBJ_OFFSET  = sdram_addr_t'(`OBJ_START >> 1);
localparam sdram_addr_t SND_OFFSET  = sdram_addr_t'(`SND_START >> 1);
localparam sdram_addr_t MAIN_OFFSET = '0;

logic [SLOT_N-1:0] slot_req;
logic [SLOT_N-1:0] slot_gnt;
logic [SLOT_N-1:0] slot_dst;
logic [SLOT_N-1:0] slot_rdy;
sdram_addr_t       slot_addr [SLOT_N];

frac_cen u_cen (
    .clk    ( clk                           ),
    .arst_n ( arst_n                        ),
    .n      ( sel60 ? `CEN_N60 : `CEN_N     ),
    .m      ( sel60 ? `CEN_M60 : `CEN_M     ),
    .cen2   ( pxl2_cen                      ),
    .cen    ( pxl_cen                       )
);

rom_dwnld u_dwnld (
    .clk         ( clk         ),
    .arst_n      ( arst_n      ),
    .downloading ( downloading ),
    .ioctl_addr  ( ioctl_addr  ),
    .ioctl_dout  ( ioctl_dout  ),
    .ioctl_wr    ( ioctl_wr    ),
    .sdram_ack   ( sdram_ack   ),
    .prog_addr   ( prog_addr   ),
    .prog_data   ( prog_data   ),
    .prog_mask   ( prog_mask   ),
    .prog_we     ( prog_we     ),
    .prom_we     ( prom_we     )
);

rom_slot #(.data_t(logic [31:0]), .AW(`SCR_AW)) u_scr (
    .clk      ( clk                  ),
    .arst_n   ( arst_n               ),
    .cs       ( scr_cs               ),
    .addr     ( scr_addr             ),
    .offset   ( SCR_OFFSET           ),
    .dout     ( scr_data             ),
    .ok       ( scr_ok               ),
    .req      ( slot_req[SLOT_SCR]   ),
    .req_addr ( slot_addr[SLOT_SCR]  ),
    .gnt      ( slot_gnt[SLOT_SCR]   ),
    .dst      ( slot_dst[SLOT_SCR]   ),
    .rdy      ( slot_rdy[SLOT_SCR]   ),
    .word     ( data_read            )
);

rom_slot #(.data_t(logic [31:0]), .AW(`OBJ_AW)) u_obj (
    .clk      ( clk                  ),
    .arst_n   ( arst_n               ),
    .cs       ( obj_cs               ),
    .addr     ( obj_addr             ),
    .offset   ( OBJ_OFFSET           ),
    .dout     ( obj_data             ),
    .ok       ( obj_ok               ),
    .req      ( slot_req[SLOT_OBJ]   ),
    .req_addr ( slot_addr[SLOT_OBJ]  ),
    .gnt      ( slot_gnt[SLOT_OBJ]   ),
    .dst      ( slot_dst[SLOT_OBJ]   ),
    .rdy      ( slot_rdy[SLOT_OBJ]   ),
    .word     ( data_read            )
);

rom_slot #(.data_t(logic [7:0]), .AW(`SND_AW)) u_snd (
    .clk      ( clk                  ),
    .arst_n   ( arst_n               ),
    .cs       ( snd_cs               ),
    .addr     ( snd_addr             ),
    .offset   ( SND_OFFSET           ),
    .dout     ( snd_data             ),
    .ok       ( snd_ok               ),
    .req      ( slot_req[SLOT_SND]   ),
    .req_addr ( slot_addr[SLOT_SND]  ),
    .gnt      ( slot_gnt[SLOT_SND]   ),
    .dst      ( slot_dst[SLOT_SND]   ),
    .rdy      ( slot_rdy[SLOT_SND]   ),
    .word     ( data_read            )
);

rom_slot #(.data_t(logic [7:0]), .AW(`MAIN_AW)) u_main (
    .clk      ( clk                  ),
    .arst_n   ( arst_n               ),
    .cs       ( main_cs              ),
    .addr     ( main_addr            ),
    .offset   ( MAIN_OFFSET          ),
    .dout     ( main_data            ),
    .ok       ( main_ok              ),
    .req      ( slot_req[SLOT_MAIN]  ),
    .req_addr ( slot_addr[SLOT_MAIN] ),
    .gnt      ( slot_gnt[SLOT_MAIN]  ),
    .dst      ( slot_dst[SLOT_MAIN]  ),
    .rdy      ( slot_rdy[SLOT_MAIN]  ),
    .word     ( data_read            )
);

rom_arbiter u_arb (
    .clk         ( clk         ),
    .arst_n      ( arst_n      ),
    .downloading ( downloading ),
    .prog_we     ( prog_we     ),
    .prog_addr   ( prog_addr   ),
    .req         ( slot_req    ),
    .req_addr    ( slot_addr   ),
    .gnt         ( slot_gnt    ),
    .dst         ( slot_dst    ),
    .rdy         ( slot_rdy    ),
    .sdram_req   ( sdram_req   ),
    .sdram_addr  ( sdram_addr  ),
    .sdram_ack   ( sdram_ack   ),
    .data_dst    ( data_dst    ),
    .data_rdy    ( data_rdy    )
);

endmodule

// File: tb/tb_clkgen.sv
`timescale 1ns/1ps

// Free-running clock and power-on reset
module tb_clkgen #(
    parameter int PERIOD     = 10,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic arst_n
);

initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
end

initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;  // Released away from the active edge
end

endmodule

// File: tb/tb_checker.sv
`timescale 1ns/1ps

// Compares DUT responses with the expected values of the current step
module tb_checker import sdram_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             downloading,
    input  logic [3:0]       cs,         // Bit order follows the slot numbers
    input  logic [3:0]       ok,
    input  logic [3:0][31:0] dout,
    input  logic [21:0]      prog_addr,
    input  logic [15:0]      prog_data,
    input  logic [1:0]       prog_mask,
    input  logic             prog_we,
    input  logic             prom_we,
    input  logic             sdram_req,
    input  sdram_addr_t      sdram_addr,
    input  logic             pxl2_cen,
    input  logic             pxl_cen,
    input  logic             step_start,
    input  logic             step_done,
    input  logic             exp_hit,
    input  logic [21:0]      exp_paddr,
    input  logic [15:0]      exp_pdata,
    input  logic [1:0]       exp_mask,
    input  int               exp_prog_n,
    input  int               exp_prom_n,
    input  int               exp_req_n,
    input  logic [3:0][21:0] exp_req,
    input  logic [3:0][31:0] exp_dout,
    input  logic             cen_win,
    input  int               cen_exp,
    output int               err_data,
    output int               err_proto
);

logic prog_q;
logic req_q;
logic win_q;
logic first;
int   n_prog;
int   n_prom;
int   n_req;
int   n_cen2;
int   n_cen;

initial begin
    err_data  = 0;
    err_proto = 0;
    prog_q    = 1'b0;
    req_q     = 1'b0;
    win_q     = 1'b0;
    first     = 1'b0;
end

always @(posedge clk) begin
    if (arst_n) begin
        if (step_start) begin
            n_prog = 0;
            n_prom = 0;
            n_req  = 0;
            first  = 1'b1;
        end
        if (first && exp_hit) begin
            for (int s = 0; s < 4; s++) begin
                if (cs[s] && !ok[s]) begin
                    $display("ERROR @%0t: slot %0d missed on a cached address", $time, s);
                    err_proto++;
                end
            end
        end
        first = 1'b0;

        if (prog_we && !prog_q) begin
            n_prog++;
            if (exp_prog_n != 0 && (prog_addr != exp_paddr || prog_data != exp_pdata
                    || prog_mask != exp_mask)) begin
                $display("ERROR @%0t: prog write %h/%h/%b, expected %h/%h/%b", $time,
                         prog_addr, prog_data, prog_mask, exp_paddr, exp_pdata, exp_mask);
                err_data++;
            end
        end
        if (prom_we) n_prom++;

        // Slot fetches only, loader writes share the port
        if (!downloading && sdram_req && !req_q) begin
            if (n_req >= exp_req_n || n_req >= 4) begin
                $display("ERROR @%0t: unexpected SDRAM request at %h", $time, sdram_addr);
                err_proto++;
            end else if (sdram_addr != exp_req[n_req]) begin
                $display("ERROR @%0t: SDRAM request %0d at %h, expected %h", $time,
                         n_req, sdram_addr, exp_req[n_req]);
                err_data++;
            end
            n_req++;
        end

        for (int s = 0; s < 4; s++) begin
            if (cs[s] && ok[s] && dout[s] != exp_dout[s]) begin
                $display("ERROR @%0t: slot %0d data %h, expected %h", $time, s,
                         dout[s], exp_dout[s]);
                err_data++;
            end
        end

        if (step_done) begin
            if (n_prog != exp_prog_n || n_prom != exp_prom_n || n_req != exp_req_n) begin
                $display("ERROR @%0t: %0d prog, %0d prom, %0d req, expected %0d, %0d, %0d",
                         $time, n_prog, n_prom, n_req, exp_prog_n, exp_prom_n, exp_req_n);
                err_proto++;
            end
        end

        // Clock enable window
        if (cen_win && !win_q) begin
            n_cen2 = 0;
            n_cen  = 0;
        end
        if (cen_win) begin
            n_cen2 += int'(pxl2_cen);
            n_cen  += int'(pxl_cen);
        end
        if (!cen_win && win_q) begin
            if (n_cen2 != cen_exp || n_cen != cen_exp / 2) begin
                $display("ERROR @%0t: %0d pxl2_cen and %0d pxl_cen, expected %0d and %0d",
                         $time, n_cen2, n_cen, cen_exp, cen_exp / 2);
                err_data++;
            end
        end

        prog_q = prog_we;
        req_q  = sdram_req;
        win_q  = cen_win;
    end
end

endmodule

// File: tb/tb_top.sv
`timescale 1ns/1ps
`include "rom_params.svh"

module tb_top import sdram_pkg::*; ();

localparam int          NREC      = 20;
localparam int          LIMIT     = NREC * 20 + 2 * 1103 + 50;
localparam logic [15:0] MODEL_KEY = 16'hA5C3;
localparam sdram_addr_t SCR_BASE  = sdram_addr_t'(`SCR_START >> 1);

logic clk;
logic arst_n;

// DUT inputs
logic                sel60;
logic                downloading;
logic [24:0]         ioctl_addr;
logic [7:0]          ioctl_dout;
logic                ioctl_wr;
logic [3:0]          cs;
logic [`SCR_AW-1:0]  scr_addr;
logic [`OBJ_AW-1:0]  obj_addr;
logic [`SND_AW-1:0]  snd_addr;
logic [`MAIN_AW-1:0] main_addr;
logic                sdram_ack;
sdram_word_t         data_read;
logic                data_dst;
logic                data_rdy;

// DUT outputs
logic        pxl2_cen, pxl_cen;
logic [21:0] prog_addr;
logic [15:0] prog_data;
logic [1:0]  prog_mask;
logic        prog_we, prom_we;
logic [31:0] scr_data, obj_data;
logic [7:0]  snd_data, main_data;
logic        scr_ok, obj_ok, snd_ok, main_ok;
logic        sdram_req;
sdram_addr_t sdram_addr;
logic [3:0]  ok_vec;

// Expected values of the running step
logic             step_start, step_done, exp_hit, cen_win;
logic [21:0]      exp_paddr;
logic [15:0]      exp_pdata;
logic [1:0]       exp_mask;
int               exp_prog_n, exp_prom_n, exp_req_n, cen_exp;
logic [3:0][21:0] exp_req;
logic [3:0][31:0] exp_dout;
int               err_data, err_proto;

// Stimulus table
logic        r_load [NREC];
logic [24:0] r_addr [NREC];
logic [7:0]  r_byte [NREC];
logic [21:0] r_paddr [NREC];
logic [1:0]  r_mask [NREC];
int          r_prog [NREC];
int          r_prom [NREC];
logic [3:0]  r_cs [NREC];
logic        r_hit [NREC];
logic [15:0] r_qa [NREC][4];
logic [31:0] r_qd [NREC][4];
int          r_req_n [NREC];
sdram_addr_t r_req [NREC][4];
int          n_rec = 0;
int          cycles = 0;
logic [7:0]  lfsr;

assign ok_vec = {main_ok, snd_ok, obj_ok, scr_ok};

tb_clkgen #(.PERIOD(10), .RST_CYCLES(2)) u_clk (.clk(clk), .arst_n(arst_n));

rom_sys_top UUT (
    .clk(clk), .arst_n(arst_n), .sel60(sel60), .pxl2_cen(pxl2_cen), .pxl_cen(pxl_cen),
    .downloading(downloading), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
    .ioctl_wr(ioctl_wr), .prog_addr(prog_addr), .prog_data(prog_data),
    .prog_mask(prog_mask), .prog_we(prog_we), .prom_we(prom_we),
    .scr_cs(cs[0]), .scr_addr(scr_addr), .scr_data(scr_data), .scr_ok(scr_ok),
    .obj_cs(cs[1]), .obj_addr(obj_addr), .obj_data(obj_data), .obj_ok(obj_ok),
    .snd_cs(cs[2]), .snd_addr(snd_addr), .snd_data(snd_data), .snd_ok(snd_ok),
    .main_cs(cs[3]), .main_addr(main_addr), .main_data(main_data), .main_ok(main_ok),
    .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_ack(sdram_ack),
    .data_read(data_read), .data_dst(data_dst), .data_rdy(data_rdy)
);

tb_checker u_chk (
    .clk(clk), .arst_n(arst_n), .downloading(downloading), .cs(cs), .ok(ok_vec),
    .dout({{24'd0, main_data}, {24'd0, snd_data}, obj_data, scr_data}),
    .prog_addr(prog_addr), .prog_data(prog_data), .prog_mask(prog_mask),
    .prog_we(prog_we), .prom_we(prom_we), .sdram_req(sdram_req), .sdram_addr(sdram_addr),
    .pxl2_cen(pxl2_cen), .pxl_cen(pxl_cen), .step_start(step_start), .step_done(step_done),
    .exp_hit(exp_hit), .exp_paddr(exp_paddr), .exp_pdata(exp_pdata), .exp_mask(exp_mask),
    .exp_prog_n(exp_prog_n), .exp_prom_n(exp_prom_n), .exp_req_n(exp_req_n),
    .exp_req(exp_req), .exp_dout(exp_dout), .cen_win(cen_win), .cen_exp(cen_exp),
    .err_data(err_data), .err_proto(err_proto)
);

// x^8 + x^6 + x^5 + x^4 + 1
function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
endfunction

function automatic logic [15:0] model_word(input sdram_addr_t a);
    return a[15:0] ^ MODEL_KEY;
endfunction

// First SDRAM word of a slot fetch
function automatic sdram_addr_t slot_word(input int s, input logic [15:0] a);
    case (s)
        0: return SCR_BASE + sdram_addr_t'({a[13:0], 1'b0});
        1: return sdram_addr_t'(`OBJ_START >> 1) + sdram_addr_t'({a[14:0], 1'b0});
        2: return sdram_addr_t'(`SND_START >> 1) + sdram_addr_t'(a[12:1]);
        default: return sdram_addr_t'(a[15:1]);
    endcase
endfunction

function automatic logic [31:0] slot_value(input int s, input logic [15:0] a);
    sdram_addr_t w;
    logic [15:0] v;
    w = slot_word(s, a);
    v = model_word(w);
    if (s < 2) return {model_word(w + 22'd1), v};
    return {24'd0, a[0] ? v[15:8] : v[7:0]};
endfunction

// Download word address with the graphics reordering
function automatic logic [21:0] map_addr(input logic [24:0] b);
    logic [21:0] w;
    logic [21:0] n;
    w = b[22:1];
    n = w;
    if (b >= 25'(`OBJ_START)) begin
        n[0]   = ~w[3];
        n[1]   = ~w[4];
        n[5:2] = {w[5], w[2:0]};
    end else if (b >= 25'(`SCR_START)) begin
        n[0]   = ~w[3];
        n[3:1] = w[2:0];
    end
    return n;
endfunction

task automatic add_load(input logic [24:0] b, input logic [7:0] d);
    r_load[n_rec]  = 1'b1;
    r_addr[n_rec]  = b;
    r_byte[n_rec]  = d;
    r_paddr[n_rec] = map_addr(b);
    r_mask[n_rec]  = b[0] ? 2'b01 : 2'b10;
    r_prom[n_rec]  = (b >= `PROM_START) ? 1 : 0;
    r_prog[n_rec]  = 1 - r_prom[n_rec];
    r_cs[n_rec]    = 4'd0;
    r_hit[n_rec]   = 1'b0;
    r_req_n[n_rec] = 0;
    for (int s = 0; s < 4; s++) r_qd[n_rec][s] = '0;
    n_rec++;
endtask

task automatic add_read(input logic [3:0] sel, input logic [15:0] a0, input logic [15:0] a1,
                        input logic [15:0] a2, input logic [15:0] a3, input logic hit);
    int order [4];
    order = '{0, 1, 3, 2};  // Main ahead of sound
    r_load[n_rec]  = 1'b0;
    r_prog[n_rec]  = 0;
    r_prom[n_rec]  = 0;
    r_cs[n_rec]    = sel;
    r_hit[n_rec]   = hit;
    r_qa[n_rec][0] = a0;
    r_qa[n_rec][1] = a1;
    r_qa[n_rec][2] = a2;
    r_qa[n_rec][3] = a3;
    r_req_n[n_rec] = 0;
    for (int s = 0; s < 4; s++) r_qd[n_rec][s] = slot_value(s, r_qa[n_rec][s]);
    for (int k = 0; k < 4; k++) begin
        if (sel[order[k]] && !hit) begin
            r_req[n_rec][r_req_n[n_rec]] = slot_word(order[k], r_qa[n_rec][order[k]]);
            r_req_n[n_rec]++;
        end
    end
    n_rec++;
endtask

task automatic measure_cen(input logic sel, input int expect_n);
    @(negedge clk);
    sel60 = sel;
    repeat (100) @(negedge clk);    // Accumulator settles to the new ratio
    cen_exp = expect_n;
    cen_win = 1'b1;
    repeat (1000) @(negedge clk);
    cen_win = 1'b0;
    repeat (2) @(negedge clk);
endtask

// SDRAM model acks one cycle after req and sends data 1 to 4 cycles later
initial begin
    sdram_addr_t a;
    logic        dl;
    logic [1:0]  dly;
    int          nw;
    sdram_ack = 1'b0;
    data_read = '0;
    data_dst  = 1'b0;
    data_rdy  = 1'b0;
    lfsr      = 8'd73;
    forever begin
        @(negedge clk);
        if (arst_n && sdram_req) begin
            a  = sdram_addr;
            dl = downloading;
            sdram_ack = 1'b1;
            @(negedge clk);
            sdram_ack = 1'b0;
            if (!dl) begin
                lfsr   = lfsr_next(lfsr);
                dly[0] = lfsr[0];
                lfsr   = lfsr_next(lfsr);
                dly[1] = lfsr[0];
                repeat (int'(dly)) @(negedge clk);
                nw = (a >= SCR_BASE) ? 2 : 1;   // Graphics words come in pairs
                for (int w = 0; w < nw; w++) begin
                    data_read = model_word(a + sdram_addr_t'(w));
                    data_dst  = 1'b1;
                    data_rdy  = (w == nw - 1);
                    @(negedge clk);
                end
                data_dst = 1'b0;
                data_rdy = 1'b0;
            end
        end
    end
end

always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
        $display("Result: FAILED");
        $finish;
    end
end

initial begin
    logic [3:0] got;
    sel60       = 1'b0;
    downloading = 1'b0;
    ioctl_addr  = '0;
    ioctl_dout  = '0;
    ioctl_wr    = 1'b0;
    cs          = 4'd0;
    scr_addr    = '0;
    obj_addr    = '0;
    snd_addr    = '0;
    main_addr   = '0;
    step_start  = 1'b0;
    step_done   = 1'b0;
    exp_hit     = 1'b0;
    exp_paddr   = '0;
    exp_pdata   = '0;
    exp_mask    = '0;
    exp_prog_n  = 0;
    exp_prom_n  = 0;
    exp_req_n   = 0;
    exp_req     = '0;
    exp_dout    = '0;
    cen_win     = 1'b0;
    cen_exp     = 0;

    add_load(25'h00_0123, 8'h5A);
    add_load(25'h00_0124, 8'hA5);
    add_load(25'h01_0007, 8'h3C);
    add_load(25'h01_202B, 8'h71);
    add_load(25'h01_200E, 8'h8E);
    add_load(25'h02_203B, 8'hC4);
    add_load(25'h02_2010, 8'h19);
    add_load(25'h04_2005, 8'hE2);
    add_load(25'h04_2100, 8'h0F);
    add_read(4'b0001, 16'h0123, 16'h0, 16'h0, 16'h0, 1'b0);
    add_read(4'b0001, 16'h0123, 16'h0, 16'h0, 16'h0, 1'b1);
    add_read(4'b0010, 16'h0, 16'h0456, 16'h0, 16'h0, 1'b0);
    add_read(4'b0100, 16'h0, 16'h0, 16'h0011, 16'h0, 1'b0);
    add_read(4'b0100, 16'h0, 16'h0, 16'h0010, 16'h0, 1'b1);   // Same word but the low byte
    add_read(4'b1000, 16'h0, 16'h0, 16'h0, 16'h1234, 1'b0);
    add_read(4'b1000, 16'h0, 16'h0, 16'h0, 16'h1235, 1'b1);
    add_read(4'b1111, 16'h0200, 16'h0301, 16'h0402, 16'h0503, 1'b0);

    @(posedge arst_n);
    for (int i = 0; i < n_rec; i++) begin
        @(negedge clk);
        exp_hit    = r_hit[i];
        exp_paddr  = r_paddr[i];
        exp_pdata  = {r_byte[i], r_byte[i]};
        exp_mask   = r_mask[i];
        exp_prog_n = r_prog[i];
        exp_prom_n = r_prom[i];
        exp_req_n  = r_req_n[i];
        for (int s = 0; s < 4; s++) begin
            exp_req[s]  = r_req[i][s];
            exp_dout[s] = r_qd[i][s];
        end
        step_start = 1'b1;
        if (r_load[i]) begin
            downloading = 1'b1;
            ioctl_addr  = r_addr[i];
            ioctl_dout  = r_byte[i];
            ioctl_wr    = 1'b1;
        end else begin
            downloading = 1'b0;
            scr_addr    = r_qa[i][0][`SCR_AW-1:0];
            obj_addr    = r_qa[i][1][`OBJ_AW-1:0];
            snd_addr    = r_qa[i][2][`SND_AW-1:0];
            main_addr   = r_qa[i][3];
            cs          = r_cs[i];
        end
        @(negedge clk);
        step_start = 1'b0;
        ioctl_wr   = 1'b0;
        if (r_load[i]) begin
            if (r_prog[i] != 0) begin
                while (!prog_we) @(negedge clk);
                while (prog_we) @(negedge clk);
            end
        end else begin
            got = ok_vec & r_cs[i];
            while (got != r_cs[i]) begin
                @(negedge clk);
                got = got | (ok_vec & r_cs[i]);
            end
            @(negedge clk);     // One more clock edge with cs high after the last fill
            cs = 4'd0;
        end
        @(negedge clk);
        step_done = 1'b1;
        @(negedge clk);
        step_done = 1'b0;
    end

    measure_cen(1'b1, 250);
    measure_cen(1'b0, 256);

    $display("Errors: %0d data, %0d protocol", err_data, err_proto);
    if (err_data + err_proto == 0) begin
        $display("Result: PASSED");
    end else begin
        $display("Result: FAILED");
    end
    $finish;
end

endmodule

// File: tb.f
+incdir+hdl
hdl/rom_map_pkg.sv
hdl/sdram_pkg.sv
hdl/frac_cen.sv
hdl/rom_dwnld.sv
hdl/rom_slot.sv
hdl/rom_arbiter.sv
hdl/rom_sys_top.sv
tb/tb_clkgen.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_top -f tb.f -o sim

run: compile
	./obj_dir/sim | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
